//--- common/lsu_cfg_pkg.sv
/*
 Widths and encodings shared by the load/store unit.
 Byte-lane masks assume a 32-bit data word with four little-endian lanes.
*/

package lsu_cfg_pkg;

   // Data and address widths
   localparam int DW     = 32;
   localparam int AW     = 32;

   // Lane geometry
   localparam int BYTE_W = 8;
   localparam int HALF_W = 16;
   localparam int BYTES  = DW / BYTE_W;     // 4 byte lanes
   localparam int HALVES = DW / HALF_W;     // 2 halfword lanes
   localparam int OFS_W  = $clog2(BYTES);   // Byte offset bits in an address

   // Access size in the execute stage opcode encoding
   typedef enum logic [2:0] {
      SIZE_NONE = 3'd0,
      SIZE_BYTE = 3'd1,
      SIZE_HALF = 3'd2,
      SIZE_WORD = 3'd3
   } lsu_size_t;

   // Write byte masks
   localparam logic [BYTES-1:0] MSK_NONE    = 4'b0000;
   localparam logic [BYTES-1:0] MSK_ALL     = 4'b1111;
   localparam logic [BYTES-1:0] MSK_LO_HALF = 4'b0011;
   localparam logic [BYTES-1:0] MSK_HI_HALF = 4'b1100;
   localparam logic [BYTES-1:0] MSK_BYTE0   = 4'b0001;  // Shifted up by the byte offset

endpackage

//--- common/lsu_types_pkg.sv
/*
 Request and data types passed between the LSU pipeline blocks.
 lsu_req_t is the full stage-1 content; only valid and misalign are reset.
*/

package lsu_types_pkg;

   import lsu_cfg_pkg::*;

   // Opcode fields from the execute stage
   typedef struct packed {
      logic      load;
      logic      store;
      logic      sign_ext;
      lsu_size_t size;
   } lsu_opc_t;

   // Stage-1 register contents
   typedef struct packed {
      logic             valid;
      logic             load;
      logic             store;
      logic             misalign;
      logic             sign_ext;
      lsu_size_t        size;
      logic [AW-1:0]    vaddr;     // Effective (virtual) address
      logic [BYTES-1:0] wmsk;      // Byte enables, zero for loads
      logic [DW-1:0]    wdat;      // Store data already replicated to its lanes
   } lsu_req_t;

   // One RAM word as byte lanes or as halfword lanes
   typedef union packed {
      logic [BYTES-1:0][BYTE_W-1:0]  b;
      logic [HALVES-1:0][HALF_W-1:0] h;
   } mem_word_u;

endpackage

//--- hw/lsu_req_stage.sv
/*
 Request stage. Decodes the opcode, checks alignment and builds the byte mask
 and replicated store data. agu_en ignores ex_valid.
 Under stall, flush_s1 still clears the valid bit; other fields hold.
*/

module lsu_req_stage (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         stall,
   input  logic                         flush_s1,
   input  logic                         ex_valid,
   input  lsu_types_pkg::lsu_opc_t      ex_lsu_opc,
   input  logic [lsu_cfg_pkg::AW-1:0]   add_sum,
   input  logic [lsu_cfg_pkg::DW-1:0]   ex_operand2,
   output logic                         agu_en,
   output lsu_types_pkg::lsu_req_t      s1_req
);

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   logic             p_cke;        // Pipeline clock enable
   logic [OFS_W-1:0] ofs;          // Byte offset within the word
   logic             misalign;
   logic [BYTES-1:0] wmsk;
   mem_word_u        wrep;         // Store data replicated across lanes
   lsu_req_t         req_d;        // Next stage-1 content
   lsu_req_t         req_q;        // Payload part of stage 1
   logic             valid_q;
   logic             misalign_q;

   assign p_cke  = ~stall;
   assign agu_en = ex_lsu_opc.load | ex_lsu_opc.store;
   assign ofs    = add_sum[OFS_W-1:0];

   // Alignment check and write byte mask
   always_comb begin
      misalign = 1'b0;
      case (ex_lsu_opc.size)
         SIZE_WORD: begin
            misalign = |ofs;
            wmsk     = MSK_ALL;
         end
         SIZE_HALF: begin
            misalign = ofs[0];
            wmsk     = ofs[OFS_W-1] ? MSK_HI_HALF : MSK_LO_HALF;
         end
         SIZE_BYTE: wmsk = MSK_BYTE0 << ofs;   // Bytes never misalign
         default:   wmsk = MSK_NONE;
      endcase
      if (!ex_lsu_opc.store)
         wmsk = MSK_NONE;                      // Loads write nothing
   end

   // Replicate store data so every candidate lane carries it
   always_comb begin
      wrep.b = ex_operand2;
      case (ex_lsu_opc.size)
         SIZE_HALF: begin
            for (int i = 0; i < HALVES; i++)
               wrep.h[i] = ex_operand2[HALF_W-1:0];
         end
         SIZE_BYTE: begin
            for (int i = 0; i < BYTES; i++)
               wrep.b[i] = ex_operand2[BYTE_W-1:0];
         end
         default: ;                            // Word passes through
      endcase
   end

   always_comb begin
      req_d.valid    = ex_valid & agu_en & ~flush_s1;
      req_d.load     = ex_lsu_opc.load;
      req_d.store    = ex_lsu_opc.store;
      req_d.misalign = misalign;
      req_d.sign_ext = ex_lsu_opc.sign_ext;
      req_d.size     = ex_lsu_opc.size;
      req_d.vaddr    = add_sum;
      req_d.wmsk     = wmsk;
      req_d.wdat     = wrep.b;
   end

   // Control bits where flush overrides stall
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q    <= 1'b0;
         misalign_q <= 1'b0;
      end else begin
         if (p_cke | flush_s1)
            valid_q <= req_d.valid;
         if (p_cke)
            misalign_q <= req_d.misalign;
      end
   end

   always_ff @(posedge clk) begin
      if (p_cke)
         req_q <= req_d;
   end

   always_comb begin
      s1_req          = req_q;
      s1_req.valid    = valid_q;
      s1_req.misalign = misalign_q;
   end

endmodule

//--- hw/lsu_data_ram.sv
/*
 Single-port data RAM, 2^RAM_AW words, byte-masked write and registered read.
 Read returns the old word on a same-edge write to that address.
 Contents are not reset.
*/

module lsu_data_ram #(
   parameter int RAM_AW = 8
) (
   input  logic                         clk,
   input  logic                         stall,
   input  lsu_types_pkg::lsu_req_t      s1_req,
   output lsu_types_pkg::mem_word_u     rdat
);

   import lsu_cfg_pkg::*;

   localparam int DEPTH = 1 << RAM_AW;

   logic [BYTES-1:0][BYTE_W-1:0] mem [DEPTH];
   logic [RAM_AW-1:0]            addr;    // Word address
   logic                         we;

   // High address bits dropped so the RAM aliases
   assign addr = s1_req.vaddr[RAM_AW+OFS_W-1:OFS_W];

   // Only a live, aligned store writes
   assign we = s1_req.valid & s1_req.store & ~s1_req.misalign & ~stall;

   always_ff @(posedge clk) begin
      if (we) begin
         for (int i = 0; i < BYTES; i++) begin
            if (s1_req.wmsk[i])
               mem[addr][i] <= s1_req.wdat[i*BYTE_W +: BYTE_W];
         end
      end
   end

   // Read every unstalled cycle; aligner decides what to use
   always_ff @(posedge clk) begin
      if (!stall)
         rdat.b <= mem[addr];
   end

endmodule

//--- hw/lsu_load_align.sv
/*
 Stage 2 of the load path. Picks the byte or halfword lane from the RAM word
 and extends it. Output follows rdat combinationally, so it holds under stall.
 SIZE_NONE yields zero.
*/

module lsu_load_align (
   input  logic                         clk,
   input  logic                         stall,
   input  lsu_types_pkg::lsu_req_t      s1_req,
   input  lsu_types_pkg::mem_word_u     rdat,
   output logic [lsu_cfg_pkg::DW-1:0]   lsu_dout
);

   import lsu_cfg_pkg::*;

   lsu_size_t         size_q;
   logic              sext_q;     // Sign extend
   logic [OFS_W-1:0]  ofs_q;      // Byte offset of the load
   logic [BYTE_W-1:0] lane_b;
   logic [HALF_W-1:0] lane_h;

   // Same enable as the RAM read register
   always_ff @(posedge clk) begin
      if (!stall) begin
         size_q <= s1_req.size;
         sext_q <= s1_req.sign_ext;
         ofs_q  <= s1_req.vaddr[OFS_W-1:0];
      end
   end

   assign lane_b = rdat.b[ofs_q];
   assign lane_h = rdat.h[ofs_q[OFS_W-1]];    // Upper offset bit picks the half

   always_comb begin
      case (size_q)
         SIZE_WORD: lsu_dout = rdat.b;
         SIZE_HALF: lsu_dout = {{(DW-HALF_W){sext_q & lane_h[HALF_W-1]}}, lane_h};
         SIZE_BYTE: lsu_dout = {{(DW-BYTE_W){sext_q & lane_b[BYTE_W-1]}}, lane_b};
         default:   lsu_dout = '0;
      endcase
   end

endmodule

//--- hw/lsu.sv
/*
 Load/store unit with a local data RAM, two pipeline stages, no handshake.
 stall freezes both stages; flush_s1 kills the request entering stage 1.
 Address bits above RAM_AW+1 are ignored, so the RAM aliases.
*/

module lsu #(
   parameter int RAM_AW = 8                        // log2 of RAM depth in words
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         stall,
   input  logic                         flush_s1,
   input  logic                         ex_valid,
   input  lsu_types_pkg::lsu_opc_t      ex_lsu_opc,
   input  logic [lsu_cfg_pkg::AW-1:0]   add_sum,     // Effective address
   input  logic [lsu_cfg_pkg::DW-1:0]   ex_operand2, // Store data
   output logic                         agu_en,
   output logic                         lsu_ealign,
   output logic [lsu_cfg_pkg::AW-1:0]   lsu_vaddr,
   output logic [lsu_cfg_pkg::DW-1:0]   lsu_dout
);

   import lsu_types_pkg::*;

   lsu_req_t  s1_req;   // Stage-1 request to RAM and aligner
   mem_word_u rdat;     // Registered RAM read word

   // Decode, mask, alignment check, stage-1 register
   lsu_req_stage u_req_stage (
      .clk         (clk),
      .arst_n      (arst_n),
      .stall       (stall),
      .flush_s1    (flush_s1),
      .ex_valid    (ex_valid),
      .ex_lsu_opc  (ex_lsu_opc),
      .add_sum     (add_sum),
      .ex_operand2 (ex_operand2),
      .agu_en      (agu_en),
      .s1_req      (s1_req)
   );

   lsu_data_ram #(
      .RAM_AW (RAM_AW)
   ) u_data_ram (
      .clk    (clk),
      .stall  (stall),
      .s1_req (s1_req),
      .rdat   (rdat)
   );

   // Stage 2 with lane select and extension
   lsu_load_align u_load_align (
      .clk      (clk),
      .stall    (stall),
      .s1_req   (s1_req),
      .rdat     (rdat),
      .lsu_dout (lsu_dout)
   );

   assign lsu_ealign = s1_req.valid & s1_req.misalign;  // Exception only for a live request
   assign lsu_vaddr  = s1_req.vaddr;

endmodule

//--- test/lsu_props.sv
/*
 Concurrent checks on the stage-1 request register of the LSU.
 Bound into every lsu_req_stage instance.
*/

module lsu_props (
   input logic                    clk,
   input logic                    arst_n,
   input lsu_types_pkg::lsu_req_t s1_req
);

   import lsu_cfg_pkg::*;

   // Loads never carry byte enables
   a_wmsk_store: assert property (@(posedge clk) disable iff (!arst_n)
      (s1_req.wmsk != '0) |-> s1_req.store)
      else $error("write mask set on a request without store");

   a_valid_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> !s1_req.valid)
      else $error("stage-1 valid high right after reset");

   // Byte accesses cannot be misaligned
   a_byte_align: assert property (@(posedge clk) disable iff (!arst_n)
      s1_req.misalign |-> (s1_req.size != SIZE_BYTE))
      else $error("misalign flagged on a byte access");

endmodule

bind lsu_req_stage lsu_props u_props (
   .clk    (clk),
   .arst_n (arst_n),
   .s1_req (s1_req)
);

//--- test/tb_lsu.sv
/*
 LSU testbench with seeded random stimulus and a two-stage reference model.
 Expects the DUT's default RAM_AW. Addresses stay in a 16-word window and
 upper address bits are random so the RAM aliasing is exercised too.
*/

module tb_lsu;

   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int RAM_AW    = 8;              // DUT default
   localparam int RESET_CY  = 10;
   localparam int DRAIN     = 3;
   localparam int N_PART    = 150;
   localparam int N_MIS     = 30;             // Pairs of cycles
   localparam int N_STALL   = 150;
   localparam int N_MIX     = 400;
   localparam int T_WORD    = 32 + DRAIN;
   localparam int T_PART    = N_PART + DRAIN;
   localparam int T_MIS     = 2 * N_MIS + DRAIN;
   localparam int T_STALL   = N_STALL + DRAIN;
   localparam int T_MIX     = N_MIX + DRAIN;
   localparam int CYC_LIMIT = RESET_CY + T_WORD + T_PART + T_MIS + T_STALL + T_MIX + 100;

   logic          clk = 1'b0;
   logic          arst_n;
   logic          stall;
   logic          flush_s1;
   logic          ex_valid;
   lsu_opc_t      ex_lsu_opc;
   logic [AW-1:0] add_sum;
   logic [DW-1:0] ex_operand2;
   logic          agu_en;
   logic          lsu_ealign;
   logic [AW-1:0] lsu_vaddr;
   logic [DW-1:0] lsu_dout;

   // Reference model of stage 1 and stage 2
   logic          m1_valid;
   lsu_opc_t      m1_opc;
   logic [AW-1:0] m1_addr;
   logic [DW-1:0] m1_data;
   logic          m2_check;                   // Stage 2 holds a comparable load
   logic [DW-1:0] m2_dout;
   logic [7:0]    mem_model [logic [RAM_AW+1:0]];

   int            checks = 0;
   int            errors = 0;
   int            test_chk0 = 0;
   int            test_err0 = 0;
   int            cyc_cnt = 0;

   lsu UUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .stall       (stall),
      .flush_s1    (flush_s1),
      .ex_valid    (ex_valid),
      .ex_lsu_opc  (ex_lsu_opc),
      .add_sum     (add_sum),
      .ex_operand2 (ex_operand2),
      .agu_en      (agu_en),
      .lsu_ealign  (lsu_ealign),
      .lsu_vaddr   (lsu_vaddr),
      .lsu_dout    (lsu_dout)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= CYC_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
         $display("Errors found");
         $finish;
      end
   end

   function automatic logic misaligned(lsu_size_t sz, logic [1:0] ofs);
      case (sz)
         SIZE_WORD: return ofs != 2'd0;
         SIZE_HALF: return ofs[0];
         default:   return 1'b0;
      endcase
   endfunction

   // Byte lanes touched by an access
   function automatic logic [3:0] lane_mask(lsu_size_t sz, logic [1:0] ofs);
      case (sz)
         SIZE_WORD: return 4'b1111;
         SIZE_HALF: return ofs[1] ? 4'b1100 : 4'b0011;
         SIZE_BYTE: return 4'b0001 << ofs;
         default:   return 4'b0000;
      endcase
   endfunction

   function automatic logic [7:0] store_byte(lsu_size_t sz, logic [DW-1:0] data,
                                             logic [1:0] lane);
      logic [3:0][7:0] d;
      d = data;
      case (sz)
         SIZE_WORD: return d[lane];
         SIZE_HALF: return d[{1'b0, lane[0]}];   // Low half repeated
         default:   return d[0];
      endcase
   endfunction

   function automatic logic [AW-1:0] make_addr(logic [3:0] word, logic [1:0] ofs);
      logic [AW-1:0] a;
      a = $urandom();
      a[RAM_AW+1:0] = {{(RAM_AW-4){1'b0}}, word, ofs};
      return a;
   endfunction

   task automatic expected_load(input lsu_opc_t opc, input logic [AW-1:0] addr,
                                output logic ok, output logic [DW-1:0] val);
      logic [3:0][7:0] w;
      logic [3:0]      msk;
      logic [15:0]     h;
      logic [7:0]      b;
      logic [1:0]      ofs;
      ofs = addr[1:0];
      msk = lane_mask(opc.size, ofs);
      ok  = 1'b1;
      w   = '0;
      for (int i = 0; i < 4; i++) begin
         if (msk[i]) begin
            if (mem_model.exists({addr[RAM_AW+1:2], 2'(i)}))
               w[i] = mem_model[{addr[RAM_AW+1:2], 2'(i)}];
            else
               ok = 1'b0;                        // Never written
         end
      end
      h = ofs[1] ? {w[3], w[2]} : {w[1], w[0]};
      b = w[ofs];
      case (opc.size)
         SIZE_WORD: val = w;
         SIZE_HALF: val = {{16{opc.sign_ext & h[15]}}, h};
         SIZE_BYTE: val = {{24{opc.sign_ext & b[7]}}, b};
         default:   val = '0;
      endcase
   endtask

   // One rising edge of the model with the inputs the DUT just saw
   task automatic advance_model();
      logic          ok;
      logic [DW-1:0] val;
      logic [3:0]    msk;
      if (stall) begin
         if (flush_s1)
            m1_valid = 1'b0;
      end else begin
         expected_load(m1_opc, m1_addr, ok, val);   // Read sees the old word
         m2_check = ok & m1_valid & m1_opc.load & ~misaligned(m1_opc.size, m1_addr[1:0]);
         m2_dout  = val;
         if (m1_valid && m1_opc.store && !misaligned(m1_opc.size, m1_addr[1:0])) begin
            msk = lane_mask(m1_opc.size, m1_addr[1:0]);
            for (int i = 0; i < 4; i++) begin
               if (msk[i])
                  mem_model[{m1_addr[RAM_AW+1:2], 2'(i)}] = store_byte(m1_opc.size, m1_data, 2'(i));
            end
         end
         m1_valid = ex_valid & (ex_lsu_opc.load | ex_lsu_opc.store) & ~flush_s1;
         m1_opc   = ex_lsu_opc;
         m1_addr  = add_sum;
         m1_data  = ex_operand2;
      end
   endtask

   task automatic check_value(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_outputs();
      logic exp_agu;
      logic exp_ea;
      exp_agu = ex_lsu_opc.load | ex_lsu_opc.store;
      exp_ea  = m1_valid & misaligned(m1_opc.size, m1_addr[1:0]);
      check_value("agu_en", {31'b0, exp_agu}, {31'b0, agu_en});
      check_value("lsu_ealign", {31'b0, exp_ea}, {31'b0, lsu_ealign});
      if (m1_valid)
         check_value("lsu_vaddr", m1_addr, lsu_vaddr);
      if (m2_check)
         check_value("lsu_dout", m2_dout, lsu_dout);
   endtask

   // Update model and check outputs before driving the next request
   task automatic step_cycle(input logic st, input logic fl, input logic vld, input logic ld,
                             input logic sto, input logic sx, input lsu_size_t sz,
                             input logic [AW-1:0] addr, input logic [DW-1:0] data);
      @(negedge clk);
      advance_model();
      check_outputs();
      stall               = st;
      flush_s1            = fl;
      ex_valid            = vld;
      ex_lsu_opc.load     = ld;
      ex_lsu_opc.store    = sto;
      ex_lsu_opc.sign_ext = sx;
      ex_lsu_opc.size     = sz;
      add_sum             = addr;
      ex_operand2         = data;
   endtask

   task automatic random_cycle(input int p_stall, input int p_flush, input int p_mis);
      lsu_size_t   sz;
      logic [1:0]  ofs;
      logic [3:0]  word;
      int unsigned r;
      int unsigned kind;
      r = $urandom_range(9, 0);
      sz = (r == 0) ? SIZE_NONE : (r < 4) ? SIZE_BYTE : (r < 7) ? SIZE_HALF : SIZE_WORD;
      word = 4'($urandom_range(15, 0));
      ofs  = 2'($urandom_range(3, 0));
      if ((sz == SIZE_HALF || sz == SIZE_WORD) && $urandom_range(99, 0) < p_mis)
         ofs = (sz == SIZE_HALF) ? {ofs[1], 1'b1} : ((ofs == 2'd0) ? 2'd2 : ofs);
      else if (sz == SIZE_HALF)
         ofs[0] = 1'b0;
      else if (sz == SIZE_WORD)
         ofs = 2'd0;
      kind = $urandom_range(9, 0);                 // 0 idle, 1-4 store, 5-9 load
      step_cycle($urandom_range(99, 0) < p_stall, $urandom_range(99, 0) < p_flush,
                 $urandom_range(9, 0) != 0, kind >= 5, kind >= 1 && kind <= 4,
                 1'($urandom_range(1, 0)), sz, make_addr(word, ofs), $urandom());
   endtask

   task automatic drain_pipe();
      repeat (DRAIN)
         step_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, SIZE_NONE, '0, '0);
   endtask

   task automatic report_test(input string name);
      $display("Test %-18s checks %0d errors %0d", name, checks - test_chk0,
               errors - test_err0);
      test_chk0 = checks;
      test_err0 = errors;
   endtask

   task automatic word_round_trip();
      for (int w = 0; w < 16; w++)
         step_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, SIZE_WORD,
                    make_addr(4'(w), 2'd0), $urandom());
      for (int w = 0; w < 16; w++)
         step_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, SIZE_WORD,
                    make_addr(4'(w), 2'd0), $urandom());
      drain_pipe();
      report_test("word_round_trip");
   endtask

   // Misaligned access, then an aligned word load of the same word
   task automatic misaligned_access();
      lsu_size_t  sz;
      logic [1:0] ofs;
      logic [3:0] word;
      logic       ld;
      for (int n = 0; n < N_MIS; n++) begin
         word = 4'($urandom_range(15, 0));
         sz   = ($urandom_range(1, 0) != 0) ? SIZE_WORD : SIZE_HALF;
         ofs  = (sz == SIZE_HALF) ? {1'($urandom_range(1, 0)), 1'b1}
                                  : 2'($urandom_range(3, 1));
         ld   = ($urandom_range(2, 0) == 0);
         step_cycle(1'b0, 1'b0, 1'b1, ld, ~ld, 1'b0, sz, make_addr(word, ofs), $urandom());
         step_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, SIZE_WORD,
                    make_addr(word, 2'd0), $urandom());
      end
      drain_pipe();
      report_test("misaligned_access");
   endtask

   initial begin
      void'($urandom(32'h28e9));
      arst_n      = 1'b0;
      stall       = 1'b0;
      flush_s1    = 1'b0;
      ex_valid    = 1'b0;
      ex_lsu_opc  = '0;
      add_sum     = '0;
      ex_operand2 = '0;
      m1_valid    = 1'b0;
      m1_opc      = '0;
      m1_addr     = '0;
      m1_data     = '0;
      m2_check    = 1'b0;
      m2_dout     = '0;
      repeat (RESET_CY) @(negedge clk);
      arst_n = 1'b1;

      word_round_trip();
      repeat (N_PART) random_cycle(0, 0, 0);       // Aligned partial stores and loads
      drain_pipe();
      report_test("partial_stores");
      misaligned_access();
      repeat (N_STALL) random_cycle(30, 20, 10);
      drain_pipe();
      report_test("stall_and_flush");
      repeat (N_MIX) random_cycle(15, 10, 10);
      drain_pipe();
      report_test("mixed_run");

      $display("Summary: checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- lsu.f
common/lsu_cfg_pkg.sv
common/lsu_types_pkg.sv
hw/lsu_req_stage.sv
hw/lsu_data_ram.sv
hw/lsu_load_align.sv
hw/lsu.sv
test/lsu_props.sv
test/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator, then scan the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --top-module tb_lsu -f lsu.f -o tb_lsu_sim

./obj_dir/tb_lsu_sim | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0
